// ==== hw/mesh_pkg.sv ====
package mesh_pkg;

  // ------------------------------
  // Router ports
  // ------------------------------
  localparam int NUM_PORTS = 5;  // Core plus four mesh neighbours

  // Port numbering used for indexing every per-port array
  typedef enum logic [2:0] {
    PORT_CORE  = 3'd0,
    PORT_NORTH = 3'd1,
    PORT_EAST  = 3'd2,
    PORT_SOUTH = 3'd3,
    PORT_WEST  = 3'd4
  } port_e;

  // One bit per port, indexed by port_e
  typedef logic [NUM_PORTS-1:0] port_mask_t;

  // ------------------------------
  // Mesh coordinates
  // ------------------------------
  localparam int COORD_W = 4;  // Up to 16 nodes per dimension

  typedef struct packed {
    logic [COORD_W-1:0] x;  // Column, grows towards east
    logic [COORD_W-1:0] y;  // Row, grows towards south
  } coord_t;

endpackage

// ==== hw/packet_pkg.sv ====
package packet_pkg;

  // ------------------------------
  // Packet payload
  // ------------------------------
  localparam int DATA_W = 8;  // Payload bits per packet

  // Single word packet
  // Validity is not part of the word, it travels on separate wires
  typedef struct packed {
    mesh_pkg::coord_t   dest;    // Destination node
    mesh_pkg::port_e    source;  // Input port the packet entered on
    logic [DATA_W-1:0]  data;    // Payload
  } packet_t;

endpackage

// ==== hw/pkt_fifo.sv ====
`timescale 1ns/1ns

module pkt_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                reset_n,
  input  packet_pkg::packet_t i_data,      // Packet from upstream
  input  logic                i_push,      // Write strobe
  input  logic                i_pop,       // Head taken by the switch
  output packet_pkg::packet_t o_head,      // Oldest stored packet
  output logic                o_head_val,  // FIFO not empty
  output logic                o_full       // No free entry
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);  // Wrap point
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

  packet_pkg::packet_t mem [FIFO_DEPTH];  // Circular storage

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // Occupancy
  logic             do_push;
  logic             do_pop;

  // A pop frees the entry on the same edge, so a full FIFO can still take a push
  assign do_pop  = i_pop & o_head_val;
  assign do_push = i_push & (~o_full | do_pop);

  // ------------------------------
  // Storage
  // ------------------------------
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;  // Wrap for any depth
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither leave the level as is
      endcase
    end
  end

  assign o_head     = mem[rd_ptr];       // Only meaningful with o_head_val
  assign o_head_val = (count != '0);
  assign o_full     = (count == FULL_CNT);

endmodule

// ==== hw/route_calc.sv ====
`timescale 1ns/1ns

module route_calc #(
  parameter int X_NODES = 4,
  parameter int Y_NODES = 4,
  parameter int X_LOC   = 1,
  parameter int Y_LOC   = 1
) (
  input  packet_pkg::packet_t  i_head,      // Packet at the FIFO head
  input  logic                 i_head_val,  // Head holds a packet
  output mesh_pkg::port_mask_t o_req        // One-hot output request
);

  // This router's position at coordinate width
  localparam logic [mesh_pkg::COORD_W-1:0] MY_X = mesh_pkg::COORD_W'(X_LOC);
  localparam logic [mesh_pkg::COORD_W-1:0] MY_Y = mesh_pkg::COORD_W'(Y_LOC);

  // Geometry must fit the coordinate fields and contain this node
  if (X_NODES > 2**mesh_pkg::COORD_W || Y_NODES > 2**mesh_pkg::COORD_W ||
      X_LOC >= X_NODES || Y_LOC >= Y_NODES) begin : g_bad_geometry
    $error("route_calc: router location does not fit the mesh");
  end

  // ------------------------------
  // XY routing
  // ------------------------------
  always_comb begin
    o_req = '0;  // No request without a head packet
    if (i_head_val) begin
      if (i_head.dest.x > MY_X) begin
        o_req[mesh_pkg::PORT_EAST] = 1'b1;   // Resolve X first
      end else if (i_head.dest.x < MY_X) begin
        o_req[mesh_pkg::PORT_WEST] = 1'b1;
      end else if (i_head.dest.y > MY_Y) begin
        o_req[mesh_pkg::PORT_SOUTH] = 1'b1;  // Then Y
      end else if (i_head.dest.y < MY_Y) begin
        o_req[mesh_pkg::PORT_NORTH] = 1'b1;
      end else begin
        o_req[mesh_pkg::PORT_CORE] = 1'b1;   // Arrived
      end
    end
  end

endmodule

// ==== hw/rr_pointer.sv ====
`timescale 1ns/1ns

module rr_pointer (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            i_advance,  // Output granted this cycle
  input  mesh_pkg::port_e i_winner,   // Input that won
  output mesh_pkg::port_e o_start     // Highest priority input
);

  // Highest port number, wraps back to core
  localparam mesh_pkg::port_e LAST_PORT = mesh_pkg::port_e'(mesh_pkg::NUM_PORTS - 1);

  // Counter modulo NUM_PORTS
  // The winner drops to lowest priority by moving the start just past it
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      o_start <= mesh_pkg::PORT_CORE;
    end else if (i_advance) begin
      if (i_winner == LAST_PORT) begin
        o_start <= mesh_pkg::PORT_CORE;
      end else begin
        o_start <= mesh_pkg::port_e'(i_winner + 3'd1);
      end
    end
  end

endmodule

// ==== hw/switch_control.sv ====
`timescale 1ns/1ns

module switch_control (
  input  logic                 clk,
  input  logic                 reset_n,
  input  mesh_pkg::port_mask_t i_req [mesh_pkg::NUM_PORTS],    // Per input, one-hot
  input  mesh_pkg::port_mask_t i_slot_free,                    // Per output slot
  output mesh_pkg::port_mask_t o_grant [mesh_pkg::NUM_PORTS],  // Per output, inputs
  output mesh_pkg::port_mask_t o_pop,                          // Per input
  output mesh_pkg::port_mask_t o_load                          // Per output slot
);

  // Slot tracking per output
  typedef enum logic [1:0] {
    ST_IDLE,     // Slot empty
    ST_SERVE,    // Slot loaded on the last edge
    ST_BLOCKED   // Slot held by downstream
  } state_e;

  for (genvar o = 0; o < mesh_pkg::NUM_PORTS; o++) begin : g_out
    mesh_pkg::port_mask_t col_req;  // Inputs that want this output
    mesh_pkg::port_mask_t grant;
    mesh_pkg::port_e      start;    // Round-robin start
    mesh_pkg::port_e      winner;
    logic                 pick_en;
    state_e               state;
    state_e               state_nxt;

    // Gather this output's column of the request matrix
    always_comb begin
      for (int i = 0; i < mesh_pkg::NUM_PORTS; i++) begin
        col_req[i] = i_req[i][o];
      end
    end

    rr_pointer u_rr_pointer (
      .clk       (clk),
      .reset_n   (reset_n),
      .i_advance (|grant),
      .i_winner  (winner),
      .o_start   (start)
    );

    // ------------------------------
    // Arbitration
    // ------------------------------
    // An idle slot is known empty, otherwise it must be draining this edge
    always_comb begin
      case (state)
        ST_IDLE: pick_en = 1'b1;
        default: pick_en = i_slot_free[o];
      endcase
    end

    // First requester at or after the pointer start
    always_comb begin : p_pick
      int   idx;
      logic found;
      grant  = '0;
      winner = mesh_pkg::PORT_CORE;
      found  = 1'b0;
      for (int k = 0; k < mesh_pkg::NUM_PORTS; k++) begin
        idx = int'(start) + k;
        if (idx >= mesh_pkg::NUM_PORTS) begin
          idx = idx - mesh_pkg::NUM_PORTS;  // Wrap around the ring
        end
        if (pick_en && !found && col_req[idx]) begin
          found      = 1'b1;
          grant[idx] = 1'b1;
          winner     = mesh_pkg::port_e'(idx);
        end
      end
    end

    assign o_grant[o] = grant;

    // ------------------------------
    // Output FSM
    // ------------------------------
    always_comb begin
      case (state)
        ST_IDLE:  state_nxt = (|grant) ? ST_SERVE : ST_IDLE;
        default: begin
          if (|grant) begin
            state_nxt = ST_SERVE;    // Reloaded as the old packet leaves
          end else if (i_slot_free[o]) begin
            state_nxt = ST_IDLE;     // Taken downstream, nothing new
          end else begin
            state_nxt = ST_BLOCKED;  // Downstream holding off
          end
        end
      endcase
    end

    always_ff @(posedge clk) begin
      if (!reset_n) begin
        state <= ST_IDLE;
      end else begin
        state <= state_nxt;
      end
    end
  end

  // Each input requests one output, so it is popped at most once
  always_comb begin
    o_pop  = '0;
    o_load = '0;
    for (int o = 0; o < mesh_pkg::NUM_PORTS; o++) begin
      o_load[o] = |o_grant[o];
      o_pop     = o_pop | o_grant[o];
    end
  end

endmodule

// ==== hw/xbar_switch.sv ====
`timescale 1ns/1ns

module xbar_switch (
  input  logic                 clk,
  input  logic                 reset_n,
  input  packet_pkg::packet_t  i_heads [mesh_pkg::NUM_PORTS],  // FIFO heads per input
  input  mesh_pkg::port_mask_t i_grant [mesh_pkg::NUM_PORTS],  // Per output, inputs
  input  mesh_pkg::port_mask_t i_load,                         // Slot write strobes
  input  mesh_pkg::port_mask_t i_en,                           // Downstream ready
  output mesh_pkg::port_mask_t o_slot_free,                    // Slot can load this edge
  output packet_pkg::packet_t  o_data [mesh_pkg::NUM_PORTS],
  output mesh_pkg::port_mask_t o_data_val
);

  packet_pkg::packet_t sel [mesh_pkg::NUM_PORTS];  // Mux outputs

  // ------------------------------
  // Crossbar multiplexers
  // ------------------------------
  always_comb begin
    for (int o = 0; o < mesh_pkg::NUM_PORTS; o++) begin
      sel[o] = '0;
      for (int i = 0; i < mesh_pkg::NUM_PORTS; i++) begin
        if (i_grant[o][i]) begin
          sel[o] = i_heads[i];  // Grant is one-hot per output
        end
      end
    end
  end

  // ------------------------------
  // Output slots
  // ------------------------------
  always_ff @(posedge clk) begin
    for (int o = 0; o < mesh_pkg::NUM_PORTS; o++) begin
      if (i_load[o]) begin
        o_data[o] <= sel[o];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      o_data_val <= '0;
    end else begin
      for (int o = 0; o < mesh_pkg::NUM_PORTS; o++) begin
        if (i_load[o]) begin
          o_data_val[o] <= 1'b1;  // New packet replaces any taken one
        end else if (i_en[o]) begin
          o_data_val[o] <= 1'b0;  // Taken downstream
        end
      end
    end
  end

  // Empty, or emptied on this edge
  assign o_slot_free = ~o_data_val | i_en;

endmodule

// ==== hw/mesh_router.sv ====
`timescale 1ns/1ns

module mesh_router #(
  parameter int X_NODES    = 4,
  parameter int Y_NODES    = 4,
  parameter int X_LOC      = 1,
  parameter int Y_LOC      = 1,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 reset_n,
  // Upstream side
  input  packet_pkg::packet_t  i_data [mesh_pkg::NUM_PORTS],
  input  mesh_pkg::port_mask_t i_data_val,
  output mesh_pkg::port_mask_t o_en,
  // Downstream side
  input  mesh_pkg::port_mask_t i_en,
  output packet_pkg::packet_t  o_data [mesh_pkg::NUM_PORTS],
  output mesh_pkg::port_mask_t o_data_val
);

  packet_pkg::packet_t  head [mesh_pkg::NUM_PORTS];   // FIFO heads
  mesh_pkg::port_mask_t req [mesh_pkg::NUM_PORTS];    // Per input requests
  mesh_pkg::port_mask_t grant [mesh_pkg::NUM_PORTS];  // Per output grants
  mesh_pkg::port_mask_t head_val;
  mesh_pkg::port_mask_t fifo_full;
  mesh_pkg::port_mask_t pop;
  mesh_pkg::port_mask_t load;
  mesh_pkg::port_mask_t slot_free;

  // ------------------------------
  // Input ports
  // ------------------------------
  for (genvar p = 0; p < mesh_pkg::NUM_PORTS; p++) begin : g_in
    assign o_en[p] = ~fifo_full[p];  // Upstream may send unless full

    pkt_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_pkt_fifo (
      .clk        (clk),
      .reset_n    (reset_n),
      .i_data     (i_data[p]),
      .i_push     (i_data_val[p] & o_en[p]),
      .i_pop      (pop[p]),
      .o_head     (head[p]),
      .o_head_val (head_val[p]),
      .o_full     (fifo_full[p])
    );

    route_calc #(
      .X_NODES (X_NODES),
      .Y_NODES (Y_NODES),
      .X_LOC   (X_LOC),
      .Y_LOC   (Y_LOC)
    ) u_route_calc (
      .i_head     (head[p]),
      .i_head_val (head_val[p]),
      .o_req      (req[p])
    );
  end

  // ------------------------------
  // Switch
  // ------------------------------
  switch_control u_switch_control (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_req       (req),
    .i_slot_free (slot_free),
    .o_grant     (grant),
    .o_pop       (pop),
    .o_load      (load)
  );

  xbar_switch u_xbar_switch (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_heads     (head),
    .i_grant     (grant),
    .i_load      (load),
    .i_en        (i_en),
    .o_slot_free (slot_free),
    .o_data      (o_data),
    .o_data_val  (o_data_val)
  );

endmodule

// ==== bench/mesh_router_assertions.sv ====
`timescale 1ns/1ns

module mesh_router_assertions (
  input logic                 clk,
  input logic                 reset_n,
  input packet_pkg::packet_t  i_out_data [mesh_pkg::NUM_PORTS],  // Router o_data
  input mesh_pkg::port_mask_t i_out_val,                         // Router o_data_val
  input mesh_pkg::port_mask_t i_out_en,                          // Downstream ready
  input mesh_pkg::port_mask_t i_grant [mesh_pkg::NUM_PORTS]      // Per output grants
);

  int fails = 0;  // Failed assertion count

  // ------------------------------
  // Per port properties
  // ------------------------------
  for (genvar p = 0; p < mesh_pkg::NUM_PORTS; p++) begin : g_port
    // Held slot keeps its word until downstream takes it
    a_hold: assert property (@(posedge clk) disable iff (!reset_n)
      (i_out_val[p] && !i_out_en[p]) |=> (i_out_val[p] && $stable(i_out_data[p])))
    else begin
      $error("output %0d changed while downstream held it off", p);
      fails = fails + 1;
    end

    a_grant: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0(i_grant[p]))  // At most one input per output
    else begin
      $error("grant for output %0d is not one-hot", p);
      fails = fails + 1;
    end
  end

  // Slots come out of reset empty
  a_reset: assert property (@(posedge clk) !reset_n |=> (i_out_val == '0))
  else begin
    $error("output valid high in the cycle after reset");
    fails = fails + 1;
  end

endmodule

bind mesh_router mesh_router_assertions u_assertions (
  .clk        (clk),
  .reset_n    (reset_n),
  .i_out_data (o_data),
  .i_out_val  (o_data_val),
  .i_out_en   (i_en),
  .i_grant    (grant)
);

// ==== bench/mesh_router_tb.sv ====
`timescale 1ns/1ns

module mesh_router_tb;

  parameter int SEED = 84;  // Random seed applied once at time zero

  localparam int NP         = mesh_pkg::NUM_PORTS;
  localparam int MESH_X     = 4;
  localparam int MESH_Y     = 4;
  localparam int MY_X       = 1;
  localparam int MY_Y       = 1;
  localparam int FIFO_DEPTH = 4;
  localparam int NUM_PKTS   = 200;
  localparam int TIMEOUT    = 2000;  // Cycles allowed per wait
  localparam int NUM_FAIR   = 40;    // Core deliveries logged for fairness
  localparam int CORE       = int'(mesh_pkg::PORT_CORE);
  localparam int EAST       = int'(mesh_pkg::PORT_EAST);

  logic                 clk;
  logic                 reset_n;
  packet_pkg::packet_t  i_data [NP];
  mesh_pkg::port_mask_t i_data_val;
  mesh_pkg::port_mask_t o_en;
  mesh_pkg::port_mask_t i_en;
  packet_pkg::packet_t  o_data [NP];
  mesh_pkg::port_mask_t o_data_val;

  // Reference model state
  packet_pkg::packet_t  exp_q [NP*NP][$];  // Per (source, output) pair in arrival order
  int                   core_src [$];      // Sources of logged core deliveries
  logic                 log_core = 1'b0;
  logic                 mon_on   = 1'b0;   // Scoreboard live once reset is released
  packet_pkg::packet_t  last_data [NP];    // Outputs at the previous sample
  mesh_pkg::port_mask_t last_val = '0;
  mesh_pkg::port_mask_t last_en  = '0;
  int                   delivered = 0;

  int route_err    = 0;  // Scoreboard counters
  int order_err    = 0;
  int hold_err     = 0;
  int misc_err     = 0;  // Main process counter
  int tests_run    = 0;
  int tests_failed = 0;

  mesh_router #(
    .X_NODES    (MESH_X),
    .Y_NODES    (MESH_Y),
    .X_LOC      (MY_X),
    .Y_LOC      (MY_Y),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_data     (i_data),
    .i_data_val (i_data_val),
    .o_en       (o_en),
    .i_en       (i_en),
    .o_data     (o_data),
    .o_data_val (o_data_val)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // ------------------------------
  // Model helpers
  // ------------------------------
  // XY rule with the X offset resolved before Y
  function automatic int xy_port(mesh_pkg::coord_t dest);
    int dx;
    int dy;
    dx = int'(dest.x) - MY_X;
    dy = int'(dest.y) - MY_Y;
    if (dx > 0) return EAST;
    if (dx < 0) return int'(mesh_pkg::PORT_WEST);
    if (dy > 0) return int'(mesh_pkg::PORT_SOUTH);
    if (dy < 0) return int'(mesh_pkg::PORT_NORTH);
    return CORE;  // Destination is this node
  endfunction

  function automatic packet_pkg::packet_t make_packet(int src, int x, int y);
    packet_pkg::packet_t pkt;
    pkt.dest.x = mesh_pkg::COORD_W'(x);
    pkt.dest.y = mesh_pkg::COORD_W'(y);
    pkt.source = mesh_pkg::port_e'(3'(src));  // Tag with the entry port
    pkt.data   = packet_pkg::DATA_W'($urandom);
    return pkt;
  endfunction

  function automatic int queued();
    int n;
    n = 0;
    for (int k = 0; k < NP*NP; k++) begin
      n = n + exp_q[k].size();
    end
    return n;
  endfunction

  function automatic int total_errors();
    return route_err + order_err + hold_err + misc_err + DUT.u_assertions.fails;
  endfunction

  // Compare one delivered word with the model
  function automatic void check_delivery(int out, packet_pkg::packet_t pkt);
    int key;
    key = int'(pkt.source) * NP + out;
    delivered++;
    if (xy_port(pkt.dest) != out) begin
      $display("error routing: packet %h expected port %0d actual port %0d",
               pkt, xy_port(pkt.dest), out);
      route_err++;
    end
    if (int'(pkt.source) >= NP || exp_q[key].size() == 0) begin
      $display("integrity_order: packet %h left port %0d with nothing outstanding for it",
               pkt, out);
      order_err++;
    end else begin
      if (exp_q[key][0] !== pkt) begin
        $display("error integrity_order: port %0d expected %h actual %h",
                 out, exp_q[key][0], pkt);
        order_err++;
      end
      void'(exp_q[key].pop_front());
    end
    if (log_core && out == CORE) begin
      core_src.push_back(int'(pkt.source));
    end
  endfunction

  // ------------------------------
  // Monitor and scoreboard
  // ------------------------------
  // Samples mid cycle where inputs and outputs are settled
  always @(negedge clk) begin : p_monitor
    if (mon_on) begin
      for (int p = 0; p < NP; p++) begin
        if (i_data_val[p] && o_en[p]) begin
          exp_q[p*NP + xy_port(i_data[p].dest)].push_back(i_data[p]);  // Accepted next edge
        end
        if (last_val[p] && !last_en[p]) begin  // Held over the last edge
          if (!o_data_val[p] || o_data[p] !== last_data[p]) begin
            $display("error backpressure_hold: port %0d expected %h valid 1 actual %h valid %b",
                     p, last_data[p], o_data[p], o_data_val[p]);
            hold_err++;
          end
        end
        if (o_data_val[p] && i_en[p]) begin
          check_delivery(p, o_data[p]);  // Leaves on the next edge
        end
      end
      last_data = o_data;
      last_val  = o_data_val;
      last_en   = i_en;
    end
  end

  // ------------------------------
  // Stimulus tasks
  // ------------------------------
  task automatic report_test(string name, int errs);
    tests_run++;
    if (errs == 0) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errs);
    end
  endtask

  // Random sources and random downstream readiness
  task automatic run_random_traffic();
    int                   sent;
    int                   cycles;
    mesh_pkg::port_mask_t taken;
    sent   = 0;
    cycles = 0;
    while ((sent < NUM_PKTS || i_data_val != '0) && cycles < TIMEOUT) begin
      @(negedge clk);
      taken = i_data_val & o_en;
      @(posedge clk);
      #1;
      i_data_val = i_data_val & ~taken;  // Accepted words retire
      for (int p = 0; p < NP; p++) begin
        if (!i_data_val[p] && sent < NUM_PKTS && ($urandom % 2) == 0) begin
          i_data[p] = make_packet(p, int'($urandom % MESH_X), int'($urandom % MESH_Y));
          i_data_val[p] = 1'b1;
          sent++;
        end
        i_en[p] = ($urandom % 4) != 0;  // Ready three cycles in four
      end
      cycles++;
    end
    if (cycles >= TIMEOUT) begin
      $display("timeout: random traffic was not accepted within %0d cycles", TIMEOUT);
      misc_err++;
    end
  endtask

  // Stop sources and open all outputs until the model empties
  task automatic drain(string name);
    int cycles;
    cycles     = 0;
    i_data_val = '0;
    i_en       = '1;
    while ((queued() != 0 || o_data_val != '0) && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (cycles >= TIMEOUT) begin
      $display("%s: %0d packets still outstanding after %0d cycles", name, queued(), TIMEOUT);
      misc_err++;
    end
  endtask

  function automatic packet_pkg::packet_t east_packet(int src);
    return make_packet(src, MY_X + 1 + int'($urandom % (MESH_X - MY_X - 1)),
                       int'($urandom % MESH_Y));
  endfunction

  task automatic fifo_full_test();
    int   accepted;
    int   cycles;
    logic taken;
    accepted = 0;
    i_en     = '0;  // Every output held off
    i_data[CORE]     = east_packet(CORE);
    i_data_val[CORE] = 1'b1;
    for (int c = 0; c < 4 * FIFO_DEPTH; c++) begin  // Window well past the fill point
      @(negedge clk);
      taken = o_en[CORE];
      @(posedge clk);
      #1;
      if (taken) begin
        accepted++;
        i_data[CORE] = east_packet(CORE);
      end
    end
    if (accepted != FIFO_DEPTH + 1) begin  // FIFO plus one output slot
      $display("error fifo_full: accepted packets expected %0d actual %0d",
               FIFO_DEPTH + 1, accepted);
      misc_err++;
    end
    i_en[EAST] = 1'b1;
    cycles     = 0;
    while (!o_en[CORE] && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!o_en[CORE]) begin
      $display("fifo_full: core input never reopened after east was enabled");
      misc_err++;
    end
  endtask

  task automatic fairness_test();
    int                   cycles;
    mesh_pkg::port_mask_t taken;
    cycles   = 0;
    log_core = 1'b1;
    i_en     = '1;
    for (int p = 0; p < NP; p++) begin
      i_data[p] = make_packet(p, MY_X, MY_Y);  // Core bound
    end
    i_data_val = '1;
    while (core_src.size() < NUM_FAIR && cycles < TIMEOUT) begin
      @(negedge clk);
      taken = i_data_val & o_en;
      @(posedge clk);
      #1;
      for (int p = 0; p < NP; p++) begin
        if (taken[p]) begin
          i_data[p] = make_packet(p, MY_X, MY_Y);  // Keep every input busy
        end
      end
      cycles++;
    end
    log_core = 1'b0;
    if (core_src.size() < NUM_FAIR) begin
      $display("fairness: only %0d core deliveries seen in %0d cycles", core_src.size(), TIMEOUT);
      misc_err++;
    end
    // Strict rotation means any five in a row cover every source
    for (int k = 1; k < core_src.size(); k++) begin
      if (core_src[k] != (core_src[k-1] + 1) % NP) begin
        $display("error fairness: delivery %0d expected source %0d actual source %0d",
                 k, (core_src[k-1] + 1) % NP, core_src[k]);
        misc_err++;
      end
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : p_main
    int base;
    int d0;
    int r0;
    int o0;
    int h0;
    void'($urandom(SEED));
    reset_n    = 1'b0;
    i_data_val = '0;
    i_en       = '1;
    for (int p = 0; p < NP; p++) begin
      i_data[p] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    reset_n = 1'b1;
    mon_on  = 1'b1;

    base = total_errors();
    @(negedge clk);
    if (o_data_val != '0) begin
      $display("error reset_state: o_data_val expected %b actual %b", 5'b0, o_data_val);
      misc_err++;
    end
    if (o_en != '1) begin
      $display("error reset_state: o_en expected %b actual %b", 5'b11111, o_en);
      misc_err++;
    end
    report_test("reset_state", total_errors() - base);
    @(posedge clk);
    #1;

    // Routing, ordering and hold share one random run
    base = misc_err;
    d0   = delivered;
    r0   = route_err;
    o0   = order_err;
    h0   = hold_err;
    run_random_traffic();
    drain("integrity_order");
    if (delivered - d0 != NUM_PKTS) begin
      $display("error routing: delivered packets expected %0d actual %0d",
               NUM_PKTS, delivered - d0);
      route_err++;
    end
    report_test("routing", route_err - r0);
    report_test("integrity_order", order_err - o0 + misc_err - base);
    report_test("backpressure_hold", hold_err - h0);

    base = total_errors();
    fifo_full_test();
    drain("fifo_full");
    report_test("fifo_full", total_errors() - base);

    base = total_errors();
    fairness_test();
    drain("fairness");
    report_test("fairness", total_errors() - base);

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
hw/mesh_pkg.sv
hw/packet_pkg.sv
hw/pkt_fifo.sv
hw/route_calc.sv
hw/rr_pointer.sv
hw/switch_control.sv
hw/xbar_switch.sv
hw/mesh_router.sv
bench/mesh_router_assertions.sv
bench/mesh_router_tb.sv

// ==== Makefile ====
# Verilator build and run of the mesh router testbench

VERILATOR ?= verilator
TOP       ?= mesh_router_tb
SEED      ?= 84
LOG       ?= sim.log
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIM_FLAGS ?= +verilator+error+limit+1000

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
	  -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN) $(SIM_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "=== FAIL ===" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -qF "=== PASS ===" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
